//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bicubic_upsample
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/bicubic_pkg.sv
`default_nettype none

package bicubic_pkg;

    typedef logic [7:0] pixel_t;

    // sign plus index into the magnitude table
    typedef struct packed {
        logic       neg;
        logic [2:0] mag;
    } weight_t;

    // tap 0 in the low nibble
    typedef weight_t [3:0] weight_set_t;

    typedef enum logic [1:0] {
        phase_5_8,
        phase_7_8,
        phase_1_8,
        phase_3_8
    } phase_t;

    // element r*4+c holds row r, column c
    typedef pixel_t [15:0] window_t;
    typedef pixel_t [3:0]  column_t;

    // element 0 is the 1/8 pixel, element 3 the 7/8 pixel
    typedef pixel_t [3:0]  out_quad_t;

    typedef struct packed {
        column_t data;
        logic    last;
    } col_beat_t;

    typedef struct packed {
        out_quad_t data;
        logic      last;
    } quad_beat_t;

    // cubic kernel magnitudes, scaled by 256
    function automatic logic [7:0] weight_mag(input logic [2:0] idx);
        case (idx)
            3'd0: return 8'd3;
            3'd1: return 8'd17;
            3'd2: return 8'd18;
            3'd3: return 8'd28;
            3'd4: return 8'd29;
            3'd5: return 8'd109;
            3'd6: return 8'd192;
            default: return 8'd248;
        endcase
    endfunction

    // nibbles listed tap 3 first
    function automatic weight_set_t phase_weights(input phase_t phase);
        case (phase)
            phase_5_8: return {4'hb, 4'h6, 4'h5, 4'h9};
            phase_7_8: return {4'ha, 4'h7, 4'h4, 4'h8};
            phase_1_8: return {4'h8, 4'h4, 4'h7, 4'ha};
            default:   return {4'h9, 4'h5, 4'h6, 4'hb};
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/bicubic_filter/horizontal_interp.sv
`default_nettype none

module horizontal_interp import bicubic_pkg::*; (
    input  column_t   columns,
    output out_quad_t quad
);

    // column phases, leftmost output first
    localparam phase_t quad_phase [4] = '{phase_1_8, phase_3_8, phase_5_8, phase_7_8};

    for (genvar i = 0; i < 4; i++) begin : g_phase
        tap_mac tap_mac_inst (
            .taps   (columns),
            .weights(phase_weights(quad_phase[i])),
            .result (quad[i])
        );
    end

endmodule

`default_nettype wire

//--- rtl/bicubic_filter/tap_mac.sv
`default_nettype none

module tap_mac import bicubic_pkg::*; (
    input  column_t     taps,
    input  weight_set_t weights,
    output pixel_t      result
);

    // worst case about 301*255, plus sign
    localparam int acc_w = 19;

    logic signed [acc_w-1:0] acc;
    logic        [acc_w-1:0] prod;
    logic signed [acc_w-1:0] scaled;

    always_comb begin
        // rounding offset
        acc  = acc_w'(128);
        prod = '0;
        for (int i = 0; i < 4; i++) begin
            prod = acc_w'(weight_mag(weights[i].mag)) * acc_w'(taps[i]);
            if (weights[i].neg) begin
                acc = acc - signed'(prod);
            end else begin
                acc = acc + signed'(prod);
            end
        end
    end

    assign scaled = acc >>> 8;

    // overshoot around edges
    always_comb begin
        if (scaled < 0) begin
            result = '0;
        end else if (scaled > 255) begin
            result = 8'd255;
        end else begin
            result = scaled[7:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/bicubic_filter/vertical_interp.sv
`default_nettype none

module vertical_interp import bicubic_pkg::*; (
    input  window_t     window,
    input  weight_set_t weights,
    output column_t     columns
);

    column_t col_taps [4];

    // regroup the window by column, row 0 as tap 0
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                col_taps[c][r] = window[r * 4 + c];
            end
        end
    end

    for (genvar c = 0; c < 4; c++) begin : g_col
        tap_mac tap_mac_inst (
            .taps   (col_taps[c]),
            .weights(weights),
            .result (columns[c])
        );
    end

endmodule

`default_nettype wire

//--- rtl/bicubic_upsample.sv
`default_nettype none

module bicubic_upsample import bicubic_pkg::*; #(
    parameter int src_width  = 4,
    parameter int src_height = 1
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      win_valid,
    output logic      win_ready,
    input  window_t   win_data,
    output logic      pix_valid,
    input  logic      pix_ready,
    output out_quad_t pix_data,
    output logic      frame_last
);

    logic        step;
    logic        row_end;
    logic        frame_end;
    weight_set_t weights;
    col_beat_t   s1_in;
    col_beat_t   s1_out;
    logic        s1_valid;
    logic        s2_ready;
    quad_beat_t  s2_in;
    quad_beat_t  s2_out;

    assign step = win_valid && win_ready;

    position_counter #(
        .src_width (src_width),
        .src_height(src_height)
    ) position_counter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .step     (step),
        .row_end  (row_end),
        .frame_end(frame_end)
    );

    upsample_phase_fsm upsample_phase_fsm_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .row_end(row_end),
        .weights(weights)
    );

    vertical_interp vertical_interp_inst (
        .window (win_data),
        .weights(weights),
        .columns(s1_in.data)
    );

    assign s1_in.last = frame_end;

    stage_reg #(.payload_t(col_beat_t)) s1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (win_valid),
        .in_ready (win_ready),
        .in_data  (s1_in),
        .out_valid(s1_valid),
        .out_ready(s2_ready),
        .out_data (s1_out)
    );

    horizontal_interp horizontal_interp_inst (
        .columns(s1_out.data),
        .quad   (s2_in.data)
    );

    assign s2_in.last = s1_out.last;

    stage_reg #(.payload_t(quad_beat_t)) s2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (s1_valid),
        .in_ready (s2_ready),
        .in_data  (s2_in),
        .out_valid(pix_valid),
        .out_ready(pix_ready),
        .out_data (s2_out)
    );

    assign pix_data   = s2_out.data;
    assign frame_last = pix_valid && s2_out.last;

endmodule

`default_nettype wire

//--- rtl/position_counter.sv
`default_nettype none

module position_counter #(
    parameter int src_width  = 4,
    parameter int src_height = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic step,
    output logic row_end,
    output logic frame_end
);

    localparam int col_w = (src_width > 1) ? $clog2(src_width) : 1;
    localparam int row_w = $clog2(4 * src_height);

    logic [col_w-1:0] col_cnt;
    logic [row_w-1:0] row_cnt;
    logic             col_last;
    logic             row_last;

    assign col_last  = col_cnt == col_w'(src_width - 1);
    assign row_last  = row_cnt == row_w'(4 * src_height - 1);
    assign row_end   = step && col_last;
    assign frame_end = row_end && row_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (step) begin
            col_cnt <= col_last ? '0 : col_cnt + 1'b1;
            // output rows, four per source row
            if (col_last) begin
                row_cnt <= row_last ? '0 : row_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // empty, or the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/upsample_phase_fsm.sv
`default_nettype none

module upsample_phase_fsm import bicubic_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        row_end,
    output weight_set_t weights
);

    phase_t phase;
    phase_t phase_next;

    // 5/8 -> 7/8 -> 1/8 -> 3/8 -> 5/8
    always_comb begin
        case (phase)
            phase_5_8: phase_next = phase_7_8;
            phase_7_8: phase_next = phase_1_8;
            phase_1_8: phase_next = phase_3_8;
            default:   phase_next = phase_5_8;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= phase_5_8;
        end else if (row_end) begin
            phase <= phase_next;
        end
    end

    assign weights = phase_weights(phase);

endmodule

`default_nettype wire

//--- testbench/bicubic_patterns.hex
// window from row 3 column 3 down to row 0 column 0, then the expected quad
// quad from the 7/8 pixel down to the 1/8 pixel; row phase steps every 4 windows
404040404040404040404040404040404040404040404040
ffffffffffffffff0000000000000000a3a3a3a3
281e140a281e140a281e140a281e140a1c1a1816
00000000ffffffffffffffff00000000ffffffff
ffffffff0000000000000000ffffffff00000000
00000000a07850288c643c14825a320a786e655b
003200ff003200ff003200ff003200ff2d150000
c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8
ffffffffffffffff00000000000000001a1a1a1a
0000000000000000ffffffff00000000f7f7f7f7
ff00ff00ff00ff00ff00ff00ff00ff000b51aef4
ffffffffffffffffffffffffffffffffffffffff
ffffffffffffffff00000000000000005c5c5c5c
00000000a07850288c643c14825a320a6d635b51
0000ffff0000ffff0000ffff0000ffff1a5ca3e5
7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
// second frame, phase back at 5/8
ffffffffffffffff0000000000000000a3a3a3a3
00000000a07850288c643c14825a320a786d6459
c8ff0000c8ff0000c8ff0000c8ff0000e9a95f1b
0101010101010101010101010101010101010101

//--- testbench/tb_bicubic_upsample.sv
`default_nettype none

module tb_bicubic_upsample import bicubic_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_patterns = 20;
    localparam int idx_w      = $clog2(n_patterns);
    localparam int frame_len  = 16;
    localparam int max_cycles = 40 * n_patterns;

    logic      clk;
    logic      rst_n;
    logic      win_valid;
    logic      win_ready;
    window_t   win_data;
    logic      pix_valid;
    logic      pix_ready;
    out_quad_t pix_data;
    logic      frame_last;

    // window in bits 159:32, expected quad below it
    logic [159:0] patterns [n_patterns];
    out_quad_t    exp_quad_q [$];
    logic         exp_last_q [$];
    int           accept_cycle_q [$];
    int           cycle;
    int           sent;
    int           received;
    int           latency;
    logic         taken;
    logic         stalled;
    out_quad_t    stalled_data;

    tb_clock_gen #(.period(10)) tb_clock_gen_inst (.clk(clk));

    bicubic_upsample #(
        .src_width (4),
        .src_height(1)
    ) bicubic_upsample_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_data  (win_data),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .frame_last(frame_last)
    );

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_quad(input out_quad_t actual, input out_quad_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    initial begin
        void'($urandom(32'h8cb5_d070));
        $readmemh("testbench/bicubic_patterns.hex", patterns);
        rst_n     = 1'b0;
        win_valid = 1'b0;
        win_data  = '0;
        pix_ready = 1'b1;
        cycle     = 0;
        sent      = 0;
        received  = 0;
        taken     = 1'b0;
        stalled   = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_flag(pix_valid, 1'b0, "pix_valid in reset");
        check_flag(frame_last, 1'b0, "frame_last in reset");
        rst_n <= 1'b1;
        wait (received == n_patterns);
        // a few more cycles so a duplicate result would still show up
        repeat (4) @(negedge clk);
        if (pix_valid) begin
            $display("pix_valid still high after all %0d results were taken", n_patterns);
            stop_with_failure();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // an offered window stays until it is taken
    always @(negedge clk) begin
        if (rst_n && (!win_valid || taken)) begin
            win_valid <= sent < n_patterns && ($urandom % 4) != 0;
            win_data  <= patterns[idx_w'(sent % n_patterns)][159:32];
        end
        // first 8 results with the sink always ready, for the latency check
        pix_ready <= received < 8 || ($urandom % 3) != 0;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= max_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     cycle, received, n_patterns);
            stop_with_failure();
        end
        taken = win_valid && win_ready;
        if (taken) begin
            exp_quad_q.push_back(patterns[idx_w'(sent)][31:0]);
            exp_last_q.push_back((sent + 1) % frame_len == 0);
            accept_cycle_q.push_back(cycle);
            sent++;
        end
        if (stalled) begin
            check_flag(pix_valid, 1'b1, "pix_valid under stall");
            check_quad(pix_data, stalled_data, "pix_data under stall");
        end
        stalled      = pix_valid && !pix_ready;
        stalled_data = pix_data;
        if (pix_valid && pix_ready) begin
            if (exp_quad_q.size() == 0) begin
                $display("result at %0d ns without any window outstanding", $time);
                stop_with_failure();
            end else begin
                check_quad(pix_data, exp_quad_q.pop_front(), $sformatf("quad %0d", received));
                check_flag(frame_last, exp_last_q.pop_front(),
                           $sformatf("frame_last of quad %0d", received));
                latency = cycle - accept_cycle_q.pop_front();
                if (received < 8 && latency != 2) begin
                    $display("Fail at %0d ns: quad %0d took %0d cycles, expected 2",
                             $time, received, latency);
                    stop_with_failure();
                end
                received++;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int period = 10
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/bicubic_pkg.sv
rtl/stage_reg.sv
rtl/position_counter.sv
rtl/upsample_phase_fsm.sv
rtl/bicubic_filter/tap_mac.sv
rtl/bicubic_filter/vertical_interp.sv
rtl/bicubic_filter/horizontal_interp.sv
rtl/bicubic_upsample.sv
testbench/tb_clock_gen.sv
testbench/tb_bicubic_upsample.sv
